/* verilog/pov_pkg.sv */
package pov_pkg;

    typedef enum logic [1:0] {
        timer_wait_first_edge,
        timer_measuring,
        timer_running
    } timer_state_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_reading,
        fetch_full
    } fetch_state_e;

    typedef enum logic [1:0] {
        shift_idle,
        shift_clock_low,
        shift_clock_high,
        shift_latch
    } shift_state_e;

    // Travels with each column from the timer down to the row mux
    typedef struct packed {
        logic [7:0] column;
        logic       first;
    } column_tag_t;

endpackage

/* verilog/column_timer.sv */
`timescale 1ns/1ps

module column_timer
    import pov_pkg::*;
#(
    parameter int COLUMN_BITS = 3
) (
    input  logic        clk_enable,
    input  logic        nrst,
    input  logic        hall,
    output logic        column_start,
    output column_tag_t column_tag
);

    localparam int PERIOD_BITS = 24;

    timer_state_e           state;
    logic [1:0]             hall_sync;
    logic                   hall_prev;
    logic                   hall_edge;
    logic [PERIOD_BITS-1:0] period_cnt;
    logic [PERIOD_BITS-1:0] slot_len;
    logic [PERIOD_BITS-1:0] slot_cnt;
    logic [COLUMN_BITS-1:0] next_column;
    logic                   columns_pending;

    // Hall input is asynchronous
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            hall_sync <= '0;
            hall_prev <= 1'b0;
        end else begin
            hall_sync <= {hall_sync[0], hall};
            hall_prev <= hall_sync[1];
        end
    end

    assign hall_edge = hall_sync[1] & ~hall_prev;

    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            state           <= timer_wait_first_edge;
            period_cnt      <= '0;
            slot_len        <= '0;
            slot_cnt        <= '0;
            next_column     <= '0;
            columns_pending <= 1'b0;
            column_start    <= 1'b0;
            column_tag      <= '0;
        end else begin
            column_start <= 1'b0;
            // Saturate on a stalled rotor
            if (period_cnt != '1) begin
                period_cnt <= period_cnt + 1'b1;
            end
            case (state)
                timer_wait_first_edge: begin
                    if (hall_edge) begin
                        state      <= timer_measuring;
                        period_cnt <= PERIOD_BITS'(1);
                    end
                end
                timer_measuring, timer_running: begin
                    if (hall_edge) begin
                        // Column 0 goes out at once on a new revolution
                        state             <= timer_running;
                        period_cnt        <= PERIOD_BITS'(1);
                        slot_len          <= period_cnt >> COLUMN_BITS;
                        slot_cnt          <= PERIOD_BITS'(1);
                        next_column       <= COLUMN_BITS'(1);
                        columns_pending   <= 1'b1;
                        column_start      <= 1'b1;
                        column_tag.column <= '0;
                        column_tag.first  <= 1'b1;
                    end else if (columns_pending) begin
                        if (slot_cnt >= slot_len) begin
                            slot_cnt          <= PERIOD_BITS'(1);
                            next_column       <= next_column + 1'b1;
                            columns_pending   <= (next_column != '1);
                            column_start      <= 1'b1;
                            column_tag.column <= 8'(next_column);
                            column_tag.first  <= 1'b0;
                        end else begin
                            slot_cnt <= slot_cnt + 1'b1;
                        end
                    end
                end
                default: state <= timer_wait_first_edge;
            endcase
        end
    end

    // The first edge only starts the period measurement
    assert property (@(posedge clk_enable) disable iff (!nrst)
        (state == timer_wait_first_edge) |-> !column_start)
        else $error("column_start while waiting for the first hall edge");

endmodule

/* verilog/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch
    import pov_pkg::*;
#(
    parameter int COLUMN_BITS   = 3,
    parameter int LANES         = 4,
    parameter int LEDS_PER_LANE = 2,
    parameter int PIXEL_BITS    = 8
) (
    input  logic                                             clk_enable,
    input  logic                                             nrst,
    input  logic                                             column_start,
    input  column_tag_t                                      column_tag,
    input  logic [PIXEL_BITS-1:0]                            ram_data,
    input  logic                                             shifter_busy,
    output logic [COLUMN_BITS+$clog2(LANES*LEDS_PER_LANE)-1:0] ram_addr,
    output logic                                             column_load,
    output logic [LANES*LEDS_PER_LANE*PIXEL_BITS-1:0]        column_data,
    output column_tag_t                                      load_tag,
    output logic                                             column_overrun
);

    localparam int WORDS     = LANES * LEDS_PER_LANE;
    localparam int WORD_BITS = $clog2(WORDS);
    localparam int ADDR_BITS = COLUMN_BITS + WORD_BITS;

    fetch_state_e         state;
    logic                 issuing;
    logic [WORD_BITS-1:0] issue_idx;
    logic                 cap_valid;
    logic [WORD_BITS-1:0] cap_idx;
    logic                 fetch_start;
    logic                 fetch_done;

    assign fetch_start = (state == fetch_idle) && column_start;
    assign fetch_done  = cap_valid && (cap_idx == WORD_BITS'(WORDS - 1));

    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            state          <= fetch_idle;
            issuing        <= 1'b0;
            issue_idx      <= '0;
            cap_valid      <= 1'b0;
            cap_idx        <= '0;
            ram_addr       <= '0;
            column_load    <= 1'b0;
            column_overrun <= 1'b0;
        end else begin
            column_load <= 1'b0;
            // RAM answers one cycle after the address
            cap_valid   <= issuing;
            cap_idx     <= issue_idx;
            if (column_start && state != fetch_idle) begin
                column_overrun <= 1'b1;
            end
            if (issuing) begin
                if (issue_idx == WORD_BITS'(WORDS - 1)) begin
                    issuing <= 1'b0;
                end else begin
                    issue_idx <= issue_idx + 1'b1;
                    ram_addr  <= ram_addr + 1'b1;
                end
            end
            case (state)
                fetch_idle: begin
                    if (column_start) begin
                        state     <= fetch_reading;
                        issuing   <= 1'b1;
                        issue_idx <= '0;
                        ram_addr  <= ADDR_BITS'(column_tag.column[COLUMN_BITS-1:0])
                                     * ADDR_BITS'(WORDS);
                    end
                end
                fetch_reading: begin
                    if (fetch_done) begin
                        if (shifter_busy) begin
                            state <= fetch_full;
                        end else begin
                            column_load <= 1'b1;
                            state       <= fetch_idle;
                        end
                    end
                end
                fetch_full: begin
                    if (!shifter_busy) begin
                        column_load <= 1'b1;
                        state       <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    // Word w sits at column_data[w*PIXEL_BITS +: PIXEL_BITS]
    always_ff @(posedge clk_enable) begin
        if (cap_valid) begin
            column_data[cap_idx*PIXEL_BITS +: PIXEL_BITS] <= ram_data;
        end
        if (fetch_start) begin
            load_tag <= column_tag;
        end
    end

    assert property (@(posedge clk_enable) disable iff (!nrst)
        column_load |-> !shifter_busy)
        else $error("column_load while the shifter is busy");

endmodule

/* verilog/driver_shifter.sv */
`timescale 1ns/1ps

module driver_shifter
    import pov_pkg::*;
#(
    parameter int LANES         = 4,
    parameter int LEDS_PER_LANE = 2,
    parameter int PIXEL_BITS    = 8
) (
    input  logic                                      clk_enable,
    input  logic                                      nrst,
    input  logic                                      column_load,
    input  logic [LANES*LEDS_PER_LANE*PIXEL_BITS-1:0] column_data,
    input  column_tag_t                               load_tag,
    output logic                                      drv_sclk,
    output logic                                      drv_gclk,
    output logic                                      drv_lat,
    output logic [LANES-1:0]                          drv_sin,
    output logic                                      shifter_busy,
    output column_tag_t                               lat_tag
);

    localparam int LANE_BITS = LEDS_PER_LANE * PIXEL_BITS;
    localparam int CNT_BITS  = $clog2(LANE_BITS);

    shift_state_e         state;
    logic [CNT_BITS-1:0]  bit_cnt;
    logic [LANE_BITS-1:0] lane_sr   [LANES];
    logic [LANE_BITS-1:0] lane_load [LANES];
    logic                 take;
    logic                 last_bit;
    logic                 advance;

    // Highest LED on top, so it is shifted first and lands in the far driver
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            for (int l = 0; l < LEDS_PER_LANE; l++) begin
                lane_load[k][l*PIXEL_BITS +: PIXEL_BITS] =
                    column_data[(l*LANES + k)*PIXEL_BITS +: PIXEL_BITS];
            end
        end
    end

    assign take     = (state == shift_idle) && column_load;
    assign last_bit = (bit_cnt == CNT_BITS'(LANE_BITS - 1));
    assign advance  = (state == shift_clock_high) && !last_bit;

    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            state        <= shift_idle;
            bit_cnt      <= '0;
            drv_sclk     <= 1'b0;
            drv_lat      <= 1'b0;
            drv_sin      <= '0;
            shifter_busy <= 1'b0;
        end else begin
            drv_sclk <= 1'b0;
            drv_lat  <= 1'b0;
            case (state)
                shift_idle: begin
                    if (take) begin
                        state        <= shift_clock_low;
                        bit_cnt      <= '0;
                        shifter_busy <= 1'b1;
                        for (int k = 0; k < LANES; k++) begin
                            drv_sin[k] <= lane_load[k][LANE_BITS-1];
                        end
                    end
                end
                shift_clock_low: begin
                    state    <= shift_clock_high;
                    drv_sclk <= 1'b1;
                end
                shift_clock_high: begin
                    if (last_bit) begin
                        state        <= shift_latch;
                        drv_lat      <= 1'b1;
                        shifter_busy <= 1'b0;
                    end else begin
                        state   <= shift_clock_low;
                        bit_cnt <= bit_cnt + 1'b1;
                        // Next bit is set up while the clock is low
                        for (int k = 0; k < LANES; k++) begin
                            drv_sin[k] <= lane_sr[k][LANE_BITS-2];
                        end
                    end
                end
                shift_latch: state <= shift_idle;
                default: state <= shift_idle;
            endcase
        end
    end

    always_ff @(posedge clk_enable) begin
        if (take) begin
            lane_sr <= lane_load;
            lat_tag <= load_tag;
        end else if (advance) begin
            for (int k = 0; k < LANES; k++) begin
                lane_sr[k] <= lane_sr[k] << 1;
            end
        end
    end

    // Grayscale clock runs free
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            drv_gclk <= 1'b0;
        end else begin
            drv_gclk <= ~drv_gclk;
        end
    end

    assert property (@(posedge clk_enable) disable iff (!nrst)
        !(drv_sclk && drv_lat))
        else $error("drv_sclk and drv_lat high together");

endmodule

/* verilog/row_mux.sv */
`timescale 1ns/1ps

module row_mux
    import pov_pkg::*;
#(
    parameter int MUX_LINES     = 8,
    parameter int BLANKING_TIME = 6
) (
    input  logic                 clk_enable,
    input  logic                 nrst,
    input  logic                 drv_lat,
    input  column_tag_t          lat_tag,
    output logic [MUX_LINES-1:0] mux_out
);

    localparam int BLANK_BITS = $clog2(BLANKING_TIME + 1);

    logic [BLANK_BITS-1:0] blank_cnt;
    logic [MUX_LINES-1:0]  row_sel;

    // Lines stay dark while the drivers take new data to avoid ghosting
    always_ff @(posedge clk_enable or negedge nrst) begin
        if (!nrst) begin
            blank_cnt <= '0;
            row_sel   <= '0;
            mux_out   <= '0;
        end else begin
            if (drv_lat) begin
                mux_out   <= '0;
                blank_cnt <= BLANK_BITS'(BLANKING_TIME - 1);
                row_sel   <= MUX_LINES'(1) << (lat_tag.column % MUX_LINES);
            end else if (blank_cnt != '0) begin
                blank_cnt <= blank_cnt - 1'b1;
            end else begin
                mux_out <= row_sel;
            end
        end
    end

endmodule

/* verilog/pov_column_engine.sv */
`timescale 1ns/1ps

module pov_column_engine
    import pov_pkg::*;
#(
    parameter int COLUMN_BITS   = 3,
    parameter int LANES         = 4,
    parameter int LEDS_PER_LANE = 2,
    parameter int PIXEL_BITS    = 8,
    parameter int MUX_LINES     = 8,
    parameter int BLANKING_TIME = 6
) (
    input  logic                                               clk_enable,
    input  logic                                               nrst,
    input  logic                                               hall,
    output logic [COLUMN_BITS+$clog2(LANES*LEDS_PER_LANE)-1:0] ram_addr,
    input  logic [PIXEL_BITS-1:0]                              ram_data,
    output logic                                               drv_sclk,
    output logic                                               drv_gclk,
    output logic                                               drv_lat,
    output logic [LANES-1:0]                                   drv_sin,
    output logic [MUX_LINES-1:0]                               mux_out,
    output logic                                               column_overrun
);

    localparam int COLUMN_WIDTH = LANES * LEDS_PER_LANE * PIXEL_BITS;

    logic                    column_start;
    column_tag_t             column_tag;
    logic                    column_load;
    logic [COLUMN_WIDTH-1:0] column_data;
    column_tag_t             load_tag;
    logic                    shifter_busy;
    column_tag_t             lat_tag;

    column_timer #(
        .COLUMN_BITS(COLUMN_BITS)
    ) u_column_timer (
        .clk_enable  (clk_enable),
        .nrst        (nrst),
        .hall        (hall),
        .column_start(column_start),
        .column_tag  (column_tag)
    );

    pixel_fetch #(
        .COLUMN_BITS  (COLUMN_BITS),
        .LANES        (LANES),
        .LEDS_PER_LANE(LEDS_PER_LANE),
        .PIXEL_BITS   (PIXEL_BITS)
    ) u_pixel_fetch (
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .column_start  (column_start),
        .column_tag    (column_tag),
        .ram_data      (ram_data),
        .shifter_busy  (shifter_busy),
        .ram_addr      (ram_addr),
        .column_load   (column_load),
        .column_data   (column_data),
        .load_tag      (load_tag),
        .column_overrun(column_overrun)
    );

    driver_shifter #(
        .LANES        (LANES),
        .LEDS_PER_LANE(LEDS_PER_LANE),
        .PIXEL_BITS   (PIXEL_BITS)
    ) u_driver_shifter (
        .clk_enable  (clk_enable),
        .nrst        (nrst),
        .column_load (column_load),
        .column_data (column_data),
        .load_tag    (load_tag),
        .drv_sclk    (drv_sclk),
        .drv_gclk    (drv_gclk),
        .drv_lat     (drv_lat),
        .drv_sin     (drv_sin),
        .shifter_busy(shifter_busy),
        .lat_tag     (lat_tag)
    );

    row_mux #(
        .MUX_LINES    (MUX_LINES),
        .BLANKING_TIME(BLANKING_TIME)
    ) u_row_mux (
        .clk_enable(clk_enable),
        .nrst      (nrst),
        .drv_lat   (drv_lat),
        .lat_tag   (lat_tag),
        .mux_out   (mux_out)
    );

endmodule

/* sim/pixel_ram_model.sv */
`timescale 1ns/1ps

module pixel_ram_model #(
    parameter int ADDR_BITS = 6,
    parameter int DATA_BITS = 8
) (
    input  logic                 clk_enable,
    input  logic [ADDR_BITS-1:0] addr,
    output logic [DATA_BITS-1:0] data
);

    logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

    // Word is valid one cycle after its address
    always_ff @(posedge clk_enable) begin
        data <= mem[addr];
    end

    task automatic load_word(input int a, input logic [DATA_BITS-1:0] value);
        mem[a] = value;
    endtask

endmodule

/* sim/pov_tb.sv */
`timescale 1ns/1ps

module pov_tb;

    localparam int COLUMN_BITS   = 3;
    localparam int LANES         = 4;
    localparam int LEDS_PER_LANE = 2;
    localparam int PIXEL_BITS    = 8;
    localparam int MUX_LINES     = 8;
    localparam int BLANKING_TIME = 6;
    localparam int ADDR_BITS     = COLUMN_BITS + $clog2(LANES * LEDS_PER_LANE);
    localparam int LANE_BITS     = LEDS_PER_LANE * PIXEL_BITS;
    localparam int HALL_PERIOD   = 512;
    localparam int NUM_TESTS     = 6;

    logic                  clk_enable;
    logic                  nrst;
    logic                  hall;
    logic [ADDR_BITS-1:0]  ram_addr;
    logic [PIXEL_BITS-1:0] ram_data;
    logic                  drv_sclk;
    logic                  drv_gclk;
    logic                  drv_lat;
    logic [LANES-1:0]      drv_sin;
    logic [MUX_LINES-1:0]  mux_out;
    logic                  column_overrun;

    logic [PIXEL_BITS-1:0] pix [2**ADDR_BITS];
    logic [LANE_BITS-1:0]  lane_cap [LANES];
    logic [LANE_BITS-1:0]  lane_lat [LANES];
    int errors = 0;
    int checks = 0;
    int lat_count = 0;
    int rows_checked = 0;
    int gclk_toggles = 0;
    int cycle = 0;
    int last_lat = 0;
    int lat_gap = 0;
    int blank_seen = 0;
    int expect_col = 0;
    int slot_expect = 0;
    int prev_period = 0;
    bit row_pending = 0;
    bit check_order = 1;
    bit overrun_seen = 0;
    bit nrst_seen = 0;
    bit gclk_prev = 0;

    pov_column_engine #(
        .COLUMN_BITS  (COLUMN_BITS),
        .LANES        (LANES),
        .LEDS_PER_LANE(LEDS_PER_LANE),
        .PIXEL_BITS   (PIXEL_BITS),
        .MUX_LINES    (MUX_LINES),
        .BLANKING_TIME(BLANKING_TIME)
    ) uut (
        .clk_enable    (clk_enable),
        .nrst          (nrst),
        .hall          (hall),
        .ram_addr      (ram_addr),
        .ram_data      (ram_data),
        .drv_sclk      (drv_sclk),
        .drv_gclk      (drv_gclk),
        .drv_lat       (drv_lat),
        .drv_sin       (drv_sin),
        .mux_out       (mux_out),
        .column_overrun(column_overrun)
    );

    pixel_ram_model #(
        .ADDR_BITS(ADDR_BITS),
        .DATA_BITS(PIXEL_BITS)
    ) pixel_ram (
        .clk_enable(clk_enable),
        .addr      (ram_addr),
        .data      (ram_data)
    );

    initial begin
        clk_enable = 1'b0;
        forever #10 clk_enable = ~clk_enable;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("ERR %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Far LED is shifted first, so its word ends up in the upper bits
    function automatic logic [LANE_BITS-1:0] expected_lane(input int col, input int k);
        logic [LANE_BITS-1:0] word;
        word = '0;
        for (int l = LEDS_PER_LANE - 1; l >= 0; l--) begin
            word = (word << PIXEL_BITS)
                   | LANE_BITS'(pix[(col * LEDS_PER_LANE + l) * LANES + k]);
        end
        return word;
    endfunction

    function automatic int onehot_index(input logic [MUX_LINES-1:0] value);
        int idx;
        int ones;
        idx = -1;
        ones = 0;
        for (int i = 0; i < MUX_LINES; i++) begin
            if (value[i] === 1'b1) begin
                idx = i;
                ones++;
            end
        end
        return (ones == 1) ? idx : -1;
    endfunction

    // With 8 columns and 8 mux lines the row index is the column itself
    task automatic check_row;
        int col;
        col = onehot_index(mux_out);
        rows_checked++;
        check_value("blank_cycles", blank_seen, BLANKING_TIME);
        if (col < 0) begin
            $display("mux_out %h is not one-hot after blanking", mux_out);
            errors++;
        end else begin
            for (int k = 0; k < LANES; k++) begin
                check_value($sformatf("drv_sin[%0d]", k), lane_lat[k], expected_lane(col, k));
            end
            if (check_order) begin
                check_value("column", col, expect_col);
                if (col != 0 && (lat_gap < slot_expect - 2 || lat_gap > slot_expect + 2)) begin
                    $display("latches %0d cycles apart, slot is %0d cycles", lat_gap,
                             slot_expect);
                    errors++;
                end
            end
        end
        expect_col++;
    endtask

    // Samples the outputs as they stood before each rising edge
    always @(posedge clk_enable) begin
        if (!nrst) begin
            row_pending  = 0;
            expect_col   = 0;
            overrun_seen = 0;
        end else begin
            if (nrst_seen) begin
                if (drv_gclk === gclk_prev) begin
                    $display("drv_gclk did not toggle at cycle %0d", cycle);
                    errors++;
                end else begin
                    gclk_toggles++;
                end
            end
            if (overrun_seen && !column_overrun) begin
                $display("column_overrun dropped without a reset");
                errors++;
            end
            if (column_overrun) begin
                overrun_seen = 1;
            end
            if (row_pending) begin
                if (mux_out == '0) begin
                    blank_seen++;
                end else begin
                    check_row();
                    row_pending = 0;
                end
            end
            if (drv_sclk) begin
                for (int k = 0; k < LANES; k++) begin
                    lane_cap[k] = {lane_cap[k][LANE_BITS-2:0], drv_sin[k]};
                end
            end
            if (drv_lat) begin
                for (int k = 0; k < LANES; k++) begin
                    lane_lat[k] = lane_cap[k];
                end
                lat_count++;
                lat_gap     = cycle - last_lat;
                last_lat    = cycle;
                blank_seen  = 0;
                row_pending = 1;
            end
        end
        gclk_prev = drv_gclk;
        nrst_seen = nrst;
        cycle++;
    end

    task automatic apply_reset;
        @(posedge clk_enable);
        nrst <= 1'b0;
        hall <= 1'b0;
        repeat (2) @(posedge clk_enable);
        nrst <= 1'b1;
        prev_period = 0;
    endtask

    // One rising hall edge at the start of every period
    task automatic run_revolutions(input int period, input int n);
        for (int r = 0; r < n; r++) begin
            if (prev_period != 0) begin
                slot_expect = prev_period >> COLUMN_BITS;
            end
            prev_period = period;
            // Each revolution starts over at column 0
            expect_col  = 0;
            for (int i = 0; i < period; i++) begin
                @(posedge clk_enable);
                hall <= (i < period / 2);
            end
        end
        @(negedge clk_enable);
    endtask

    task automatic test_reset_state;
        int l0;
        apply_reset();
        @(negedge clk_enable);
        check_value("drv_sclk", drv_sclk, 0);
        check_value("drv_lat", drv_lat, 0);
        check_value("drv_gclk", drv_gclk, 0);
        check_value("drv_sin", drv_sin, 0);
        check_value("mux_out", mux_out, 0);
        check_value("column_overrun", column_overrun, 0);
        l0 = lat_count;
        run_revolutions(HALL_PERIOD, 1);
        check_value("latch_count", lat_count - l0, 0);
    endtask

    task automatic test_column_data;
        int l0;
        l0 = lat_count;
        run_revolutions(HALL_PERIOD, 3);
        check_value("latch_count", lat_count - l0, 3 << COLUMN_BITS);
    endtask

    task automatic test_row_mux;
        int r0;
        r0 = rows_checked;
        run_revolutions(HALL_PERIOD, 2);
        check_value("rows_checked", rows_checked - r0, 2 << COLUMN_BITS);
    endtask

    task automatic test_gclk;
        int g0;
        g0 = gclk_toggles;
        run_revolutions(HALL_PERIOD, 1);
        check_value("gclk_toggles", gclk_toggles - g0, HALL_PERIOD);
    endtask

    task automatic test_column_count;
        int l0;
        l0 = lat_count;
        run_revolutions(768, 3);
        check_value("latch_count", lat_count - l0, 3 << COLUMN_BITS);
        check_value("column_overrun", column_overrun, 0);
    endtask

    // Slot of 20 cycles is shorter than fetch plus shift
    task automatic test_overrun;
        int r0;
        check_order = 0;
        r0 = rows_checked;
        run_revolutions(160, 6);
        check_value("column_overrun", column_overrun, 1);
        if (rows_checked == r0) begin
            $display("no column reached the drivers during overrun");
            errors++;
        end
        apply_reset();
        @(negedge clk_enable);
        check_value("column_overrun", column_overrun, 0);
        check_order = 1;
    endtask

    initial begin
        int unsigned seed;
        int unsigned rnd;
        nrst = 1'b0;
        hall = 1'b0;
        seed = 32'h82c5;
        rnd  = $urandom(seed);
        for (int a = 0; a < 2**ADDR_BITS; a++) begin
            pix[a] = PIXEL_BITS'(rnd);
            pixel_ram.load_word(a, pix[a]);
            rnd = $urandom;
        end
        test_reset_state();
        test_column_data();
        test_row_mux();
        test_gclk();
        test_column_count();
        test_overrun();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(12 * HALL_PERIOD * NUM_TESTS * 20);
        $display("Timeout, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* files.f */
verilog/pov_pkg.sv
verilog/column_timer.sv
verilog/pixel_fetch.sv
verilog/driver_shifter.sv
verilog/row_mux.sv
verilog/pov_column_engine.sv
sim/pixel_ram_model.sv
sim/pov_tb.sv
